/* src/video_pkg.sv */
package video_pkg;

    // chip model code, bit 0 set on the pal parts
    typedef enum logic [1:0] {
        ntsc_r8   = 2'd0,
        pal_r3    = 2'd1,
        ntsc_r56a = 2'd2,
        pal_r1    = 2'd3
    } chip_t;

    typedef struct packed {
        logic [9:0] raster_x;
        logic [8:0] raster_y;
    } raster_pos_t;

    typedef struct packed {
        logic [5:0] luma;      // luma level of the pixel colour
        logic [7:0] phase;     // chroma phase, 256 steps per colour cycle
        logic [3:0] amplitude; // chroma amplitude, 0 is no colour
    } pixel_color_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;      // native visible area
        logic white_px;    // marker pixel at visible start
        logic eq;          // equalization pulse
        logic se;          // serration pulse
        logic vblank_line; // one of the nine pulse lines
        logic pulse_kind;  // 1 = serration line, 0 = equalization line
        logic odd_line;
        logic new_line;
    } sync_flags_t;

    localparam logic [5:0] white_burst_level = 6'd59;
    localparam logic [5:0] chroma_center     = 6'd32;  // top bits of the 256 offset

    // burst phases, 180 deg ntsc and +/-135 deg pal
    localparam logic [7:0] burst_phase_ntsc     = 8'd128;
    localparam logic [7:0] burst_phase_pal_even = 8'd96;
    localparam logic [7:0] burst_phase_pal_odd  = 8'd160;

    localparam logic [3:0] no_modulation = 4'd0;

    localparam logic [9:0] burst_start_ntsc = 10'd50;
    localparam logic [9:0] burst_start_pal  = 10'd49;

    // raster positions per line: 65, 64 and 63 cycles of 8 pixels
    localparam logic [9:0] line_len_r8   = 10'd520;
    localparam logic [9:0] line_len_r56a = 10'd512;
    localparam logic [9:0] line_len_pal  = 10'd504;

    localparam logic [9:0] eq_width_ntsc = 10'd18;  // ~2.3us
    localparam logic [9:0] eq_width_pal  = 10'd17;
    localparam logic [9:0] se_gap        = 10'd37;  // blank tail of each half line

endpackage

/* src/raster_decoder.sv */
`timescale 1ns/1ps

module raster_decoder (
    input  logic                    clk_col16x,
    input  logic                    rst_n,
    input  video_pkg::raster_pos_t  pos,
    input  video_pkg::chip_t        chip,
    input  video_pkg::pixel_color_t color,
    input  logic                    white_line,
    output video_pkg::sync_flags_t  flags,
    output video_pkg::pixel_color_t color_q,
    output logic [9:0]              raster_x_q
);

    video_pkg::raster_pos_t  pos_s;  // input sample stage
    video_pkg::pixel_color_t color_s;
    logic                    white_line_s;
    logic [8:0]              prev_y;

    logic [9:0] hsync_start;
    logic [9:0] hsync_end;
    logic [9:0] hvisible_start;
    logic [8:0] vvisible_end;
    logic [8:0] vblank_start;
    logic [8:0] vblank_end;
    logic [8:0] vvisible_start;
    logic [9:0] line_len;
    logic [9:0] half_line;
    logic [9:0] eq_width;

    logic [9:0] x;
    logic [8:0] y;

    assign x = pos_s.raster_x;
    assign y = pos_s.raster_y;
    assign half_line = {1'b0, line_len[9:1]};

    // window limits per chip model, ntsc x ~122ns and pal x ~127ns
    always_comb begin
        if (chip[0]) begin
            hsync_start    = 10'd7;   // ~1us after line start
            hsync_end      = 10'd44;  // 37 positions, ~4.7us
            hvisible_start = 10'd91;
            vvisible_end   = 9'd300;
            vblank_start   = 9'd301;
            vblank_end     = 9'd309;  // nine pulse lines
            vvisible_start = 9'd310;
            line_len       = video_pkg::line_len_pal;
            eq_width       = video_pkg::eq_width_pal;
        end else begin
            hsync_start    = 10'd8;
            hsync_end      = 10'd45;
            hvisible_start = 10'd96;
            vvisible_end   = 9'd13;
            vblank_start   = 9'd14;
            vblank_end     = 9'd22;
            vvisible_start = 9'd23;
            line_len       = (chip == video_pkg::ntsc_r8) ? video_pkg::line_len_r8
                                                          : video_pkg::line_len_r56a;
            eq_width       = video_pkg::eq_width_ntsc;
        end
    end

    always_ff @(posedge clk_col16x) begin
        pos_s        <= pos;
        color_s      <= color;
        white_line_s <= white_line;
        color_q      <= color_s;      // keeps colour aligned with the flags
        raster_x_q   <= x;
    end

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            flags  <= '0;
            prev_y <= '0;
        end else begin
            flags.hsync <= x >= hsync_start && x < hsync_end;
            // vsync opens at hsync of the first pulse line, closes at hsync end of the last
            flags.vsync <= ((y == vblank_start && x >= hsync_start) || y > vblank_start) &&
                           (y < vblank_end || (y == vblank_end && x < hsync_end));
            flags.active <= !(x < hvisible_start ||
                              (y >= vvisible_end &&
                               ((y == vvisible_start && x <= hvisible_start) ||
                                y < vvisible_start)));
            flags.white_px <= x == hvisible_start && white_line_s;
            flags.eq <= x < eq_width || (x >= half_line && x < half_line + eq_width);
            // serration is low only in the last 37 positions of each half line
            flags.se <= !((x >= half_line - se_gap_w() && x < half_line) ||
                          x >= line_len - se_gap_w());
            flags.vblank_line <= y >= vblank_start && y <= vblank_end;
            flags.pulse_kind  <= y >= vblank_start + 9'd3 && y <= vblank_start + 9'd5;
            flags.odd_line    <= y[0];
            flags.new_line    <= y != prev_y;
            prev_y            <= y;
        end
    end

    function automatic logic [9:0] se_gap_w();
        return video_pkg::se_gap;
    endfunction

    // horizontal sync lies wholly inside the blanked start of line
    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        !(flags.hsync && flags.active));

endmodule

/* src/luma_sequencer.sv */
`timescale 1ns/1ps

module luma_sequencer (
    input  logic                    clk_col16x,
    input  logic                    rst_n,
    input  video_pkg::sync_flags_t  flags,
    input  video_pkg::pixel_color_t color_q,
    input  logic [5:0]              blanking_level,
    output logic [5:0]              luma_level,
    output logic                    sink_level
);

    logic pulse;  // sync pulse that applies on the current pulse line

    // lines 3..5 of the vblank group carry serration, the rest equalization
    assign pulse = flags.pulse_kind ? flags.se : flags.eq;

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            luma_level <= 6'd0;
            sink_level <= 1'b0;
        end else if (flags.vblank_line) begin
            luma_level <= pulse ? 6'd0 : blanking_level;  // sync tip during the pulse
            sink_level <= pulse;
        end else begin
            sink_level <= flags.hsync;
            if (flags.hsync) begin
                luma_level <= 6'd0;
            end else if (!flags.active) begin
                luma_level <= blanking_level;  // front/back porch and blank lines
            end else if (flags.white_px) begin
                luma_level <= video_pkg::white_burst_level;
            end else begin
                luma_level <= color_q.luma;
            end
        end
    end

endmodule

/* src/chroma_modulator.sv */
`timescale 1ns/1ps

module chroma_modulator #(
    parameter int burst_cycles = 9
) (
    input  logic                    clk_col16x,
    input  logic                    rst_n,
    input  video_pkg::sync_flags_t  flags,
    input  video_pkg::pixel_color_t color_q,
    input  logic [9:0]              raster_x_q,
    input  video_pkg::chip_t        chip,
    input  logic [3:0]              burst_amplitude,
    output logic [11:0]             rom_addr,
    output logic                    modulated
);

    localparam int burst_len = burst_cycles * 16;  // 16 samples per colour cycle
    localparam int cnt_w     = $clog2(burst_len + 1);

    logic             pal;
    logic [3:0]       phase_cnt;  // free running, one colour cycle per wrap
    logic [cnt_w-1:0] burst_cnt;
    logic             need_burst;  // armed on each new line
    logic             in_burst;
    logic [9:0]       burst_start;
    logic [3:0]       amplitude;
    logic [7:0]       phase_off;
    logic [7:0]       wave_addr;

    assign pal         = chip[0];
    assign burst_start = pal ? video_pkg::burst_start_pal : video_pkg::burst_start_ntsc;

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            phase_cnt <= 4'd0;
        end else begin
            phase_cnt <= phase_cnt + 4'd1;
        end
    end

    // burst runs once per line, burst_len cycles from the burst start position
    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            need_burst <= 1'b0;
            in_burst   <= 1'b0;
            burst_cnt  <= '0;
        end else begin
            if (in_burst) begin
                if (burst_cnt == cnt_w'(burst_len - 1)) begin
                    in_burst  <= 1'b0;
                    burst_cnt <= '0;
                end else begin
                    burst_cnt <= burst_cnt + 1'b1;
                end
            end else if (need_burst && raster_x_q >= burst_start) begin
                in_burst   <= 1'b1;
                need_burst <= 1'b0;
            end
            if (flags.new_line)
                need_burst <= 1'b1;  // re-arm wins over a start in the same cycle
        end
    end

    // amplitude picks one of the sixteen sine tables
    always_comb begin
        if (flags.vsync)
            amplitude = video_pkg::no_modulation;
        else if (flags.active)
            amplitude = flags.white_px ? video_pkg::no_modulation : color_q.amplitude;
        else if (in_burst)
            amplitude = burst_amplitude;
        else
            amplitude = video_pkg::no_modulation;
    end

    always_comb begin
        if (flags.active) begin
            if (flags.white_px)
                phase_off = 8'd0;
            else if (pal && flags.odd_line)
                phase_off = 8'd255 - color_q.phase;  // pal swings v on alternate lines
            else
                phase_off = color_q.phase;
        end else if (pal) begin
            phase_off = flags.odd_line ? video_pkg::burst_phase_pal_odd
                                       : video_pkg::burst_phase_pal_even;
        end else begin
            phase_off = video_pkg::burst_phase_ntsc;
        end
    end

    assign wave_addr = {phase_cnt, 4'b0000} + phase_off;  // wraps mod 256

    always_ff @(posedge clk_col16x) begin
        rom_addr <= {amplitude, wave_addr};
    end

    always_ff @(posedge clk_col16x) begin
        if (!rst_n)
            modulated <= 1'b0;
        else
            modulated <= amplitude != video_pkg::no_modulation;
    end

    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        burst_cnt < cnt_w'(burst_len));

endmodule

/* src/sine_table.sv */
`timescale 1ns/1ps

module sine_table (
    input  logic        clk_col16x,
    input  logic [11:0] addr,  // {amplitude, phase}
    output logic [8:0]  data
);

    localparam real two_pi = 6.283185307179586;

    logic [8:0] rom [4096];

    // 256 + round(amp * 8 * sin(2 pi phase / 256)), spans 136..376
    function automatic logic [8:0] sine_entry(input int idx);
        real ang;
        real level;
        int  amp;
        int  rounded;
        amp   = idx / 256;
        ang   = two_pi * real'(idx % 256) / 256.0;
        level = real'(amp) * 8.0 * $sin(ang);
        // half away from zero
        rounded = $rtoi(level + ((level < 0.0) ? -0.5 : 0.5));
        return 9'(256 + rounded);
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++)
            rom[i] = sine_entry(i);
    end

    always_ff @(posedge clk_col16x) begin
        data <= rom[addr];  // one cycle read
    end

endmodule

/* src/video_out_stage.sv */
`timescale 1ns/1ps

module video_out_stage #(
    parameter bit invert_luma = 1'b1
) (
    input  logic       clk_col16x,
    input  logic       rst_n,
    input  logic [5:0] luma_level,
    input  logic       sink_level,
    input  logic [8:0] rom_data,
    input  logic       modulated,
    output logic [5:0] luma_out,
    output logic       luma_sink,
    output logic [5:0] chroma_out
);

    logic [5:0] luma_d;  // held one stage for the rom read
    logic       sink_d;
    logic       mod_d;   // lines up with rom_data

    always_ff @(posedge clk_col16x) begin
        if (!rst_n) begin
            luma_d     <= 6'd0;
            sink_d     <= 1'b0;
            mod_d      <= 1'b0;
            luma_out   <= {6{invert_luma}};
            luma_sink  <= 1'b0;
            chroma_out <= video_pkg::chroma_center;
        end else begin
            luma_d     <= luma_level;
            sink_d     <= sink_level;
            mod_d      <= modulated;
            luma_out   <= luma_d ^ {6{invert_luma}};  // board amp inverts again
            luma_sink  <= sink_d;
            // unmodulated chroma sits at mid scale
            chroma_out <= mod_d ? rom_data[8:3] : video_pkg::chroma_center;
        end
    end

    // the sink is only pulled while the luma sits at the sync tip
    assert property (@(posedge clk_col16x) disable iff (!rst_n)
        sink_level |-> ##2 (luma_sink && (luma_out ^ {6{invert_luma}}) == 6'd0));

endmodule

/* src/composite_encoder.sv */
`timescale 1ns/1ps

module composite_encoder #(
    parameter int burst_cycles = 9,
    parameter bit invert_luma  = 1'b1
) (
    input  logic                    clk_col16x,
    input  logic                    rst_n,
    input  video_pkg::raster_pos_t  pos,
    input  video_pkg::chip_t        chip,
    input  video_pkg::pixel_color_t color,
    input  logic                    white_line,
    input  logic [5:0]              blanking_level,
    input  logic [3:0]              burst_amplitude,
    output logic [5:0]              luma_out,
    output logic                    luma_sink,
    output logic [5:0]              chroma_out
);

    video_pkg::sync_flags_t  flags;
    video_pkg::pixel_color_t color_q;
    logic [9:0]              raster_x_q;
    logic [5:0]              luma_level;
    logic                    sink_level;
    logic [11:0]             rom_addr;
    logic [8:0]              rom_data;
    logic                    modulated;

    raster_decoder u_raster_decoder (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .pos        (pos),
        .chip       (chip),
        .color      (color),
        .white_line (white_line),
        .flags      (flags),
        .color_q    (color_q),
        .raster_x_q (raster_x_q)
    );

    luma_sequencer u_luma_sequencer (
        .clk_col16x     (clk_col16x),
        .rst_n          (rst_n),
        .flags          (flags),
        .color_q        (color_q),
        .blanking_level (blanking_level),
        .luma_level     (luma_level),
        .sink_level     (sink_level)
    );

    chroma_modulator #(
        .burst_cycles (burst_cycles)
    ) u_chroma_modulator (
        .clk_col16x      (clk_col16x),
        .rst_n           (rst_n),
        .flags           (flags),
        .color_q         (color_q),
        .raster_x_q      (raster_x_q),
        .chip            (chip),
        .burst_amplitude (burst_amplitude),
        .rom_addr        (rom_addr),
        .modulated       (modulated)
    );

    sine_table u_sine_table (
        .clk_col16x (clk_col16x),
        .addr       (rom_addr),
        .data       (rom_data)
    );

    video_out_stage #(
        .invert_luma (invert_luma)
    ) u_video_out_stage (
        .clk_col16x (clk_col16x),
        .rst_n      (rst_n),
        .luma_level (luma_level),
        .sink_level (sink_level),
        .rom_data   (rom_data),
        .modulated  (modulated),
        .luma_out   (luma_out),
        .luma_sink  (luma_sink),
        .chroma_out (chroma_out)
    );

endmodule

/* test/tb_composite_encoder.sv */
`timescale 1ns/1ps

module tb_composite_encoder;

    // one edge worth of sampled inputs
    typedef struct packed {
        video_pkg::raster_pos_t  pos;
        video_pkg::pixel_color_t color;
        logic                    white_line;
        logic [5:0]              blank;
        logic [3:0]              burst_amp;
    } in_sample_t;

    localparam int burst_len = 9 * 16;  // burst_cycles of the top level, 16 samples each

    logic                    clk_col16x = 1'b0;
    logic                    rst_n;
    video_pkg::raster_pos_t  pos;
    video_pkg::chip_t        chip;
    video_pkg::chip_t        next_chip;
    video_pkg::pixel_color_t color;
    logic                    white_line;
    logic [5:0]              blanking_level;
    logic [3:0]              burst_amplitude;
    logic [5:0]              luma_out;
    logic                    luma_sink;
    logic [5:0]              chroma_out;

    in_sample_t hist [8];  // indexed by edge number mod 8
    int edge_no;
    int e0;                // first edge that sees rst_n high
    int cur_x;
    int cur_y;
    int tick;              // pixel advances every 4 clocks
    int need_burst;
    int in_burst;
    int burst_cnt;
    int y_prev;
    int cov_eq;
    int cov_se;
    int cov_burst;
    int cov_marker;

    composite_encoder u_composite_encoder (
        .clk_col16x      (clk_col16x),
        .rst_n           (rst_n),
        .pos             (pos),
        .chip            (chip),
        .color           (color),
        .white_line      (white_line),
        .blanking_level  (blanking_level),
        .burst_amplitude (burst_amplitude),
        .luma_out        (luma_out),
        .luma_sink       (luma_sink),
        .chroma_out      (chroma_out)
    );

    always #10 clk_col16x = ~clk_col16x;

    function automatic int line_positions(input video_pkg::chip_t c);
        if (c[0])
            return 504;
        return (c == video_pkg::ntsc_r8) ? 520 : 512;
    endfunction

    // 256 + round(amp * 8 * sin(2 pi phase / 256))
    function automatic int sine_value(input int amp, input int ph);
        real level;
        level = amp * 8.0 * $sin(6.283185307179586 * ph / 256.0);
        return 256 + int'($floor(level + 0.5));
    endfunction

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // new line, biased towards the pulse lines and the visible start
    task automatic next_line();
        int vb0;
        int r;
        vb0 = chip[0] ? 301 : 14;
        r = $urandom_range(0, 99);
        cur_x = 0;
        if (r < 50)
            cur_y = (cur_y + 1) % (chip[0] ? 312 : (chip == video_pkg::ntsc_r8 ? 263 : 262));
        else if (r < 80)
            cur_y = vb0 - 1 + $urandom_range(0, 10);
        else if (r < 92)
            cur_y = vb0 + 8 + $urandom_range(0, 2);
        else
            cur_y = $urandom_range(0, 261);
        color           <= 18'($urandom);
        white_line      <= 1'($urandom_range(0, 1));
        blanking_level  <= 6'($urandom);
        burst_amplitude <= 4'($urandom);
    endtask

    task automatic drive_inputs(input bit hold_reset);
        rst_n <= !hold_reset;
        chip  <= next_chip;
        tick = (tick + 1) % 4;
        if (tick == 0) begin
            cur_x++;
            if (cur_x >= line_positions(chip))
                next_line();
            else if ($urandom_range(0, 499) == 0)
                cur_x = $urandom_range(0, line_positions(chip) - 1);  // jump inside the line
        end
        pos <= {10'(cur_x), 9'(cur_y)};
    endtask

    // outputs of this edge belong to the inputs sampled 4 edges back
    task automatic check_edge();
        in_sample_t s;
        in_sample_t late;  // blank and burst levels are used two edges later
        int x, y, pal, hs0, vb0, hvis, len, half, eqw;
        int luma, amp, off, ph, chroma;
        bit hs, vs, act, mark, vbl, se_line, pulse, sink;
        string where;
        s = hist[(edge_no - 4) % 8];
        late = hist[(edge_no - 2) % 8];
        x = int'(s.pos.raster_x);
        y = int'(s.pos.raster_y);
        pal = chip[0] ? 1 : 0;
        hs0 = pal ? 7 : 8;
        vb0 = pal ? 301 : 14;       // first of the nine pulse lines
        hvis = pal ? 91 : 96;
        eqw = pal ? 17 : 18;
        len = line_positions(chip);
        half = len / 2;
        where = $sformatf(" at x %0d y %0d", x, y);
        hs = x >= hs0 && x < hs0 + 37;
        vs = ((y == vb0 && x >= hs0) || y > vb0) &&
             (y < vb0 + 8 || (y == vb0 + 8 && x < hs0 + 37));
        act = x >= hvis && !(y >= vb0 - 1 && (y < vb0 + 9 || (y == vb0 + 9 && x <= hvis)));
        mark = x == hvis && s.white_line;
        vbl = y >= vb0 && y <= vb0 + 8;
        se_line = y >= vb0 + 3 && y <= vb0 + 5;
        if (se_line)
            pulse = !((x >= half - 37 && x < half) || x >= len - 37);  // tip except the gaps
        else
            pulse = x < eqw || (x >= half && x < half + eqw);
        if (vbl) begin
            sink = pulse;
            luma = pulse ? 0 : int'(late.blank);
        end else begin
            sink = hs;
            luma = hs ? 0 : (!act ? int'(late.blank) : (mark ? 59 : int'(s.color.luma)));
        end
        if (vs)
            amp = 0;
        else if (act)
            amp = mark ? 0 : int'(s.color.amplitude);
        else
            amp = in_burst ? int'(late.burst_amp) : 0;
        if (act)
            off = mark ? 0 : ((pal && y % 2 == 1) ? 255 - int'(s.color.phase)
                                                   : int'(s.color.phase));
        else
            off = pal ? (y % 2 == 1 ? 160 : 96) : 128;
        ph = ((edge_no - 2 - e0) % 16 * 16 + off) % 256;   // counter mirrored from reset
        chroma = (amp == 0) ? 32 : sine_value(amp, ph) / 8;
        check_value({"luma_out", where}, int'(luma_out), 63 - luma);
        check_value({"luma_sink", where}, int'(luma_sink), int'(sink));
        check_value({"chroma_out", where}, int'(chroma_out), chroma);
        cov_eq += (vbl && !se_line) ? 1 : 0;
        cov_se += (vbl && se_line) ? 1 : 0;
        cov_burst += (!vs && !act && in_burst == 1 && amp != 0) ? 1 : 0;
        cov_marker += (act && mark) ? 1 : 0;
        // burst armed by a new line, started at the first late enough position
        if (in_burst == 1) begin
            burst_cnt++;
            if (burst_cnt == burst_len) begin
                in_burst = 0;
                burst_cnt = 0;
            end
        end else if (need_burst == 1 && x >= (pal ? 49 : 50)) begin
            in_burst = 1;
            need_burst = 0;
        end
        if (y != y_prev)
            need_burst = 1;
        y_prev = y;
    endtask

    task automatic run_cycle(input bit hold_reset);
        @(posedge clk_col16x);
        edge_no++;
        drive_inputs(hold_reset);
        @(negedge clk_col16x);
        if (edge_no >= e0 + 3)
            check_edge();
        hist[(edge_no + 1) % 8] = {pos, color, white_line, blanking_level, burst_amplitude};
    endtask

    task automatic apply_reset(input video_pkg::chip_t c);
        next_chip = c;
        e0 = 1 << 30;
        cur_x = 0;
        cur_y = c[0] ? 299 : 12;  // a line or two before the pulse lines
        repeat (8) run_cycle(1'b1);
        check_value("luma_out in reset", int'(luma_out), 63);
        check_value("luma_sink in reset", int'(luma_sink), 0);
        check_value("chroma_out in reset", int'(chroma_out), 32);
        need_burst = 0;
        in_burst = 0;
        burst_cnt = 0;
        y_prev = 0;
        run_cycle(1'b0);
        e0 = edge_no + 1;
    endtask

    task automatic run_segment(input video_pkg::chip_t c);
        int n;
        apply_reset(c);
        cov_eq = 0;
        cov_se = 0;
        cov_burst = 0;
        cov_marker = 0;
        n = 0;
        while (n < 60000 || cov_eq == 0 || cov_se == 0 || cov_burst < burst_len ||
               cov_marker == 0) begin
            if (n == 1500000) begin
                $display("Timeout: chip %s never covered all pulse, burst and marker cases",
                         c.name());
                $display("Regression failed");
                $fatal(1, "coverage wait timed out");
            end
            run_cycle(1'b0);
            n++;
        end
    endtask

    initial begin
        void'($urandom(57));
        rst_n           = 1'b0;
        pos             = '0;
        chip            = video_pkg::ntsc_r8;
        next_chip       = video_pkg::ntsc_r8;
        color           = '0;
        white_line      = 1'b0;
        blanking_level  = 6'd20;
        burst_amplitude = 4'd6;
        edge_no = 0;
        e0 = 1 << 30;
        tick = 0;
        run_segment(video_pkg::ntsc_r8);
        run_segment(video_pkg::pal_r3);
        run_segment(video_pkg::ntsc_r56a);
        run_segment(video_pkg::pal_r1);
        run_segment(video_pkg::chip_t'($urandom_range(0, 3)));
        $display("Regression passed");
        $finish;
    end

endmodule

/* src.f */
src/video_pkg.sv
src/raster_decoder.sv
src/luma_sequencer.sv
src/chroma_modulator.sv
src/sine_table.sv
src/video_out_stage.sv
src/composite_encoder.sv
test/tb_composite_encoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_composite_encoder
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }
	@echo "simulation done, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
